/* build.f */
src/kcpu_pkg.sv
src/reg_port_if.sv
src/stack_bus_if.sv
src/stack_ram.sv
src/kcpu_regs.sv
src/stack_seq.sv
src/kcpu_stack_top.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_top
./obj_dir/Vtb_top 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* src/kcpu_pkg.sv */
// ====================
// shared types of the register and stack block
// register codes follow the 6809 TFR/EXG encoding
// codes 6, 7 and 12..15 read as zero and write nothing
// ====================
package kcpu_pkg;

    typedef logic [15:0] word_t;   // 16-bit register or stack pointer
    typedef logic [7:0]  byte_t;   // 8-bit register or stack byte
    typedef logic [7:0]  post_t;   // postbyte or push/pull mask
    typedef logic [3:0]  reg_code_t;

    localparam reg_code_t RC_D  = 4'h0;
    localparam reg_code_t RC_X  = 4'h1;
    localparam reg_code_t RC_Y  = 4'h2;
    localparam reg_code_t RC_U  = 4'h3;
    localparam reg_code_t RC_S  = 4'h4;
    localparam reg_code_t RC_PC = 4'h5;   // source only
    localparam reg_code_t RC_A  = 4'h8;
    localparam reg_code_t RC_B  = 4'h9;
    localparam reg_code_t RC_CC = 4'ha;
    localparam reg_code_t RC_DP = 4'hb;

    typedef enum logic [2:0] {
        CMD_LD, CMD_TFR, CMD_PSHS, CMD_PSHU, CMD_PULS, CMD_PULU
    } cmd_op_t;

    typedef enum logic [1:0] {
        WB_NONE, WB_LOAD, WB_XFER, WB_PULL
    } wb_op_t;

    // stack_seq states
    typedef enum logic [2:0] {
        IDLE, EXEC, PUSH, PULL_ADDR, PULL_DATA, FINISH
    } seq_state_t;

endpackage

/* src/kcpu_regs.sv */
// ====================
// A, B, DP, CC, X, Y, U, S register file
// PC comes in from outside, TFR source only
// push serves highest mask bit, pull lowest
// bit 6 of a mask is always the other stack
// ====================
`timescale 1ns/1ns

module kcpu_regs (
    input  logic            clk,
    input  logic            rst,
    input  kcpu_pkg::word_t pc,
    reg_port_if.regs        rp,
    stack_bus_if.regs       sb,
    output kcpu_pkg::word_t reg_d,
    output kcpu_pkg::word_t reg_x,
    output kcpu_pkg::word_t reg_y,
    output kcpu_pkg::word_t reg_u,
    output kcpu_pkg::word_t reg_s,
    output kcpu_pkg::byte_t reg_dp,
    output kcpu_pkg::byte_t reg_cc
);
    kcpu_pkg::byte_t a, b, dp, cc;
    kcpu_pkg::word_t x, y, u, s;
    kcpu_pkg::word_t sp, sp_other;    // stack in use and the other one
    kcpu_pkg::word_t xfer_val, wb_val;
    kcpu_pkg::word_t psh_word;
    logic [2:0]      psh_idx;
    logic            psh_any;

    assign sp       = rp.psh_ussel ? u : s;
    assign sp_other = rp.psh_ussel ? s : u;

    // TFR source, 8-bit sources widen with FF
    always_comb begin
        case (rp.post[7:4])
            kcpu_pkg::RC_D:  xfer_val = {a, b};
            kcpu_pkg::RC_X:  xfer_val = x;
            kcpu_pkg::RC_Y:  xfer_val = y;
            kcpu_pkg::RC_U:  xfer_val = u;
            kcpu_pkg::RC_S:  xfer_val = s;
            kcpu_pkg::RC_PC: xfer_val = pc;
            kcpu_pkg::RC_A:  xfer_val = {8'hff, a};
            kcpu_pkg::RC_B:  xfer_val = {8'hff, b};
            kcpu_pkg::RC_CC: xfer_val = {8'hff, cc};
            kcpu_pkg::RC_DP: xfer_val = {8'hff, dp};
            default:         xfer_val = '0;
        endcase
    end

    assign wb_val = (rp.wb_op == kcpu_pkg::WB_LOAD) ? rp.imm : xfer_val;

    // priority encoder, last hit in the loop wins
    always_comb begin
        psh_idx = '0;
        if (rp.push_dir) begin
            for (int i = 0; i < 7; i++)
                if (rp.psh_sel[i]) psh_idx = 3'(i);
        end else begin
            for (int i = 6; i >= 0; i--)
                if (rp.psh_sel[i]) psh_idx = 3'(i);
        end
    end

    assign psh_any     = |rp.psh_sel[6:0];
    assign rp.psh_bit  = psh_any ? (8'h01 << psh_idx) : 8'h00;
    assign rp.psh_wide = psh_any && (psh_idx >= 3'd4);   // X, Y, other SP

    always_comb begin
        case (psh_idx)
            3'd0:    psh_word = {8'h00, cc};
            3'd1:    psh_word = {8'h00, a};
            3'd2:    psh_word = {8'h00, b};
            3'd3:    psh_word = {8'h00, dp};
            3'd4:    psh_word = x;
            3'd5:    psh_word = y;
            default: psh_word = sp_other;
        endcase
    end

    assign sb.wdata = rp.psh_hilon ? psh_word[15:8] : psh_word[7:0];
    assign sb.addr  = rp.push_dir ? sp - 16'd1 : sp;   // pre-decrement push

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= '0;
            b  <= '0;
            dp <= '0;
            cc <= '0;
            x  <= '0;
            y  <= '0;
            u  <= '0;
            s  <= '0;
        end else begin
            if (rp.wb_op == kcpu_pkg::WB_LOAD || rp.wb_op == kcpu_pkg::WB_XFER) begin
                case (rp.post[3:0])
                    kcpu_pkg::RC_D: begin
                        a <= wb_val[15:8];
                        b <= wb_val[7:0];
                    end
                    kcpu_pkg::RC_X:  x  <= wb_val;
                    kcpu_pkg::RC_Y:  y  <= wb_val;
                    kcpu_pkg::RC_U:  u  <= wb_val;
                    kcpu_pkg::RC_S:  s  <= wb_val;
                    kcpu_pkg::RC_A:  a  <= wb_val[7:0];
                    kcpu_pkg::RC_B:  b  <= wb_val[7:0];
                    kcpu_pkg::RC_CC: cc <= wb_val[7:0];
                    kcpu_pkg::RC_DP: dp <= wb_val[7:0];
                    default: ;   // PC and unused codes
                endcase
            end
            if (rp.step && rp.push_dir) begin
                if (rp.psh_ussel) u <= u - 16'd1;
                else              s <= s - 16'd1;
            end
            if (rp.step && rp.wb_op == kcpu_pkg::WB_PULL) begin
                case (psh_idx)
                    3'd0: cc <= sb.rdata;
                    3'd1: a  <= sb.rdata;
                    3'd2: b  <= sb.rdata;
                    3'd3: dp <= sb.rdata;
                    3'd4: if (rp.psh_hilon) x[15:8] <= sb.rdata; else x[7:0] <= sb.rdata;
                    3'd5: if (rp.psh_hilon) y[15:8] <= sb.rdata; else y[7:0] <= sb.rdata;
                    default: begin
                        // other stack pointer, never the one being walked
                        if (rp.psh_ussel && rp.psh_hilon)  s[15:8] <= sb.rdata;
                        if (rp.psh_ussel && !rp.psh_hilon) s[7:0]  <= sb.rdata;
                        if (!rp.psh_ussel && rp.psh_hilon)  u[15:8] <= sb.rdata;
                        if (!rp.psh_ussel && !rp.psh_hilon) u[7:0]  <= sb.rdata;
                    end
                endcase
                if (rp.psh_ussel) u <= u + 16'd1;
                else              s <= s + 16'd1;
            end
        end
    end

    assign reg_d  = {a, b};
    assign reg_x  = x;
    assign reg_y  = y;
    assign reg_u  = u;
    assign reg_s  = s;
    assign reg_dp = dp;
    assign reg_cc = cc;

endmodule

/* src/kcpu_stack_top.sv */
// ====================
// register and stack block of the CPU core
// one command at a time, no back-pressure
// done pulses once, registers already updated
// ====================
`timescale 1ns/1ns

module kcpu_stack_top #(
    parameter int STACK_AW = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  kcpu_pkg::cmd_op_t cmd_op,
    input  kcpu_pkg::post_t   cmd_post,
    input  kcpu_pkg::word_t   cmd_imm,
    input  kcpu_pkg::word_t   pc,
    output logic              busy,
    output logic              done,
    output kcpu_pkg::word_t   reg_d,
    output kcpu_pkg::word_t   reg_x,
    output kcpu_pkg::word_t   reg_y,
    output kcpu_pkg::word_t   reg_u,
    output kcpu_pkg::word_t   reg_s,
    output kcpu_pkg::byte_t   reg_dp,
    output kcpu_pkg::byte_t   reg_cc
);
    reg_port_if  rp ();
    stack_bus_if sb ();

    stack_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_post  (cmd_post),
        .cmd_imm   (cmd_imm),
        .busy      (busy),
        .done      (done),
        .rp        (rp.seq),
        .sb        (sb.seq)
    );

    kcpu_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .rp     (rp.regs),
        .sb     (sb.regs),
        .reg_d  (reg_d),
        .reg_x  (reg_x),
        .reg_y  (reg_y),
        .reg_u  (reg_u),
        .reg_s  (reg_s),
        .reg_dp (reg_dp),
        .reg_cc (reg_cc)
    );

    stack_ram #(.STACK_AW(STACK_AW)) u_ram (
        .clk (clk),
        .sb  (sb.ram)
    );

endmodule

/* src/reg_port_if.sv */
// ====================
// sequencer to register file link
// psh_bit/psh_wide come back combinationally
// from the current psh_sel and push_dir
// ====================
`timescale 1ns/1ns

interface reg_port_if;
    kcpu_pkg::wb_op_t wb_op;
    kcpu_pkg::post_t  post;
    kcpu_pkg::word_t  imm;
    kcpu_pkg::post_t  psh_sel;     // remaining push/pull mask
    logic             psh_hilon;   // high byte now
    logic             psh_ussel;   // U stack in use
    logic             push_dir;
    logic             step;        // commit one stack byte
    kcpu_pkg::post_t  psh_bit;     // one-hot, bit being served
    logic             psh_wide;

    modport seq (
        output wb_op, post, imm, psh_sel, psh_hilon, psh_ussel, push_dir, step,
        input  psh_bit, psh_wide
    );
    modport regs (
        input  wb_op, post, imm, psh_sel, psh_hilon, psh_ussel, push_dir, step,
        output psh_bit, psh_wide
    );
endinterface

/* src/stack_bus_if.sv */
// ====================
// stack RAM bus, byte wide
// addr carries the full stack pointer
// rdata is valid the cycle after re
// ====================
`timescale 1ns/1ns

interface stack_bus_if;
    kcpu_pkg::word_t addr;
    kcpu_pkg::byte_t wdata;
    kcpu_pkg::byte_t rdata;
    logic            we;
    logic            re;

    modport regs (output addr, wdata, input rdata);
    modport seq  (output we, re);
    modport ram  (input addr, wdata, we, re, output rdata);
endinterface

/* src/stack_ram.sv */
// ====================
// byte wide stack memory, 2**STACK_AW deep
// only the low STACK_AW address bits are used,
// so the stack wraps at the RAM depth
// contents are undefined after power up
// ====================
`timescale 1ns/1ns

module stack_ram #(
    parameter int STACK_AW = 8
) (
    input  logic     clk,
    stack_bus_if.ram sb
);
    localparam int DEPTH = 1 << STACK_AW;

    kcpu_pkg::byte_t        mem [0:DEPTH-1];
    logic [STACK_AW-1:0]    idx;

    assign idx = sb.addr[STACK_AW-1:0];

    always_ff @(posedge clk) begin
        if (sb.we)
            mem[idx] <= sb.wdata;
        if (sb.re)
            sb.rdata <= mem[idx];   // one cycle read latency
    end

endmodule

/* src/stack_seq.sv */
// ====================
// command FSM for LD, TFR, push and pull
// push is one cycle per byte, pull two
// a cmd_valid while busy is dropped
// PC (mask bit 7) is never pushed or pulled
// ====================
`timescale 1ns/1ns

module stack_seq (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  kcpu_pkg::cmd_op_t cmd_op,
    input  kcpu_pkg::post_t   cmd_post,
    input  kcpu_pkg::word_t   cmd_imm,
    output logic              busy,
    output logic              done,
    reg_port_if.seq           rp,
    stack_bus_if.seq          sb
);
    kcpu_pkg::seq_state_t state;
    kcpu_pkg::cmd_op_t    op_q;
    kcpu_pkg::post_t      mask_q, mask_nx;
    kcpu_pkg::post_t      post_q;
    kcpu_pkg::word_t      imm_q;
    logic                 half2;       // second byte of a 16-bit register
    logic                 last_byte;

    assign last_byte = !rp.psh_wide || half2;
    assign mask_nx   = last_byte ? (mask_q & ~rp.psh_bit) : mask_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= kcpu_pkg::IDLE;
            op_q   <= kcpu_pkg::CMD_LD;
            mask_q <= '0;
            half2  <= 1'b0;
        end else begin
            case (state)
                kcpu_pkg::IDLE: if (cmd_valid) begin
                    op_q   <= cmd_op;
                    mask_q <= cmd_post & 8'h7f;   // drop PC bit
                    half2  <= 1'b0;
                    case (cmd_op)
                        kcpu_pkg::CMD_LD, kcpu_pkg::CMD_TFR:
                            state <= kcpu_pkg::EXEC;
                        kcpu_pkg::CMD_PSHS, kcpu_pkg::CMD_PSHU:
                            state <= (cmd_post[6:0] == 7'd0) ? kcpu_pkg::FINISH
                                                              : kcpu_pkg::PUSH;
                        kcpu_pkg::CMD_PULS, kcpu_pkg::CMD_PULU:
                            state <= (cmd_post[6:0] == 7'd0) ? kcpu_pkg::FINISH
                                                              : kcpu_pkg::PULL_ADDR;
                        default: state <= kcpu_pkg::FINISH;
                    endcase
                end
                kcpu_pkg::EXEC: state <= kcpu_pkg::FINISH;
                kcpu_pkg::PUSH: begin
                    mask_q <= mask_nx;
                    half2  <= !last_byte;
                    if (mask_nx == 8'h00) state <= kcpu_pkg::FINISH;
                end
                kcpu_pkg::PULL_ADDR: state <= kcpu_pkg::PULL_DATA;
                kcpu_pkg::PULL_DATA: begin
                    mask_q <= mask_nx;
                    half2  <= !last_byte;
                    state  <= (mask_nx == 8'h00) ? kcpu_pkg::FINISH : kcpu_pkg::PULL_ADDR;
                end
                default: state <= kcpu_pkg::IDLE;   // FINISH
            endcase
        end
    end

    // operands for LD/TFR
    always_ff @(posedge clk) begin
        if (state == kcpu_pkg::IDLE && cmd_valid) begin
            post_q <= cmd_post;
            imm_q  <= cmd_imm;
        end
    end

    always_comb begin
        case (state)
            kcpu_pkg::EXEC:
                rp.wb_op = (op_q == kcpu_pkg::CMD_LD) ? kcpu_pkg::WB_LOAD : kcpu_pkg::WB_XFER;
            kcpu_pkg::PULL_DATA: rp.wb_op = kcpu_pkg::WB_PULL;
            default:             rp.wb_op = kcpu_pkg::WB_NONE;
        endcase
    end

    assign busy         = (state != kcpu_pkg::IDLE);
    assign done         = (state == kcpu_pkg::FINISH);
    assign rp.post      = post_q;
    assign rp.imm       = imm_q;
    assign rp.psh_sel   = mask_q;
    assign rp.push_dir  = (op_q == kcpu_pkg::CMD_PSHS) || (op_q == kcpu_pkg::CMD_PSHU);
    assign rp.psh_ussel = (op_q == kcpu_pkg::CMD_PSHU) || (op_q == kcpu_pkg::CMD_PULU);
    assign rp.psh_hilon = rp.push_dir ? half2 : !half2;   // push low first, pull high first
    assign rp.step      = (state == kcpu_pkg::PUSH) || (state == kcpu_pkg::PULL_DATA);
    assign sb.we        = (state == kcpu_pkg::PUSH);
    assign sb.re        = (state == kcpu_pkg::PULL_ADDR);

endmodule

/* verification/tb_top.sv */
// ====================
// random command testbench for kcpu_stack_top
// model of the registers and a 256-byte stack, so STACK_AW must stay 8
// the whole RAM is written through S before any pull is issued
// LCG seed 60393, 300 random commands after the directed sweeps
// ====================
`timescale 1ns/1ns

module tb_top;
    localparam int STACK_AW     = 8;
    localparam int DONE_TIMEOUT = 64;
    localparam logic [23:0] BIT_CODES = 24'h21b98a;   // mask bit 0..5 -> CC A B DP X Y

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    kcpu_pkg::cmd_op_t cmd_op;
    kcpu_pkg::post_t   cmd_post;
    kcpu_pkg::word_t   cmd_imm;
    kcpu_pkg::word_t   pc;
    logic              busy;
    logic              done;
    kcpu_pkg::word_t   reg_d, reg_x, reg_y, reg_u, reg_s;
    kcpu_pkg::byte_t   reg_dp, reg_cc;

    kcpu_pkg::byte_t m_a, m_b, m_dp, m_cc;
    kcpu_pkg::word_t m_x, m_y, m_u, m_s;
    kcpu_pkg::word_t msp;                       // stack pointer while walking a list
    kcpu_pkg::word_t pc_val;
    kcpu_pkg::byte_t stack_mem [0:(1<<STACK_AW)-1];
    logic [31:0]     seed;

    kcpu_stack_top #(.STACK_AW(STACK_AW)) uut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input kcpu_pkg::word_t got, input kcpu_pkg::word_t exp,
                              input string name);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: register %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input kcpu_pkg::byte_t got, input kcpu_pkg::byte_t exp,
                              input string name);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: register %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic compare_all();
        check_word(reg_d, {m_a, m_b}, "D");
        check_word(reg_x, m_x, "X");
        check_word(reg_y, m_y, "Y");
        check_word(reg_u, m_u, "U");
        check_word(reg_s, m_s, "S");
        check_byte(reg_dp, m_dp, "DP");
        check_byte(reg_cc, m_cc, "CC");
    endtask

    // 8-bit registers read back with FF on top
    function automatic kcpu_pkg::word_t model_read(input logic [3:0] code,
                                                   input kcpu_pkg::word_t pc_in);
        case (code)
            4'h0:    return {m_a, m_b};
            4'h1:    return m_x;
            4'h2:    return m_y;
            4'h3:    return m_u;
            4'h4:    return m_s;
            4'h5:    return pc_in;
            4'h8:    return {8'hff, m_a};
            4'h9:    return {8'hff, m_b};
            4'ha:    return {8'hff, m_cc};
            4'hb:    return {8'hff, m_dp};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic model_write(input logic [3:0] code, input kcpu_pkg::word_t v);
        case (code)
            4'h0: {m_a, m_b} = v;
            4'h1: m_x = v;
            4'h2: m_y = v;
            4'h3: m_u = v;
            4'h4: m_s = v;
            4'h8: m_a = v[7:0];
            4'h9: m_b = v[7:0];
            4'ha: m_cc = v[7:0];
            4'hb: m_dp = v[7:0];
            default: ;   // PC and unused codes
        endcase
    endtask

    task automatic push_byte(input kcpu_pkg::byte_t v);
        msp = msp - 16'd1;
        stack_mem[msp[STACK_AW-1:0]] = v;
    endtask

    task automatic pull_byte(output kcpu_pkg::byte_t v);
        v = stack_mem[msp[STACK_AW-1:0]];
        msp = msp + 16'd1;
    endtask

    // push walks the mask from bit 6 down, pull from bit 0 up
    task automatic model_stack(input logic use_u, input logic is_push,
                               input kcpu_pkg::post_t mask);
        int              i;
        logic [3:0]      code;
        kcpu_pkg::word_t v;
        kcpu_pkg::byte_t hi, lo;
        msp = use_u ? m_u : m_s;
        for (int n = 0; n < 7; n++) begin
            i = is_push ? 6 - n : n;
            if (mask[i]) begin
                code = (i == 6) ? (use_u ? 4'h4 : 4'h3) : BIT_CODES[i*4 +: 4];
                if (is_push) begin
                    v = model_read(code, 16'h0000);
                    push_byte(v[7:0]);              // low byte first
                    if (i >= 4) push_byte(v[15:8]);
                end else begin
                    pull_byte(hi);
                    if (i >= 4) begin
                        pull_byte(lo);
                        model_write(code, {hi, lo});
                    end else begin
                        model_write(code, {8'h00, hi});
                    end
                end
            end
        end
        if (use_u) m_u = msp;
        else       m_s = msp;
    endtask

    task automatic run_cmd(input kcpu_pkg::cmd_op_t op, input kcpu_pkg::post_t post,
                           input kcpu_pkg::word_t imm, input logic junk);
        int          cycles;
        logic [31:0] r;
        r = next_rand();
        pc_val = r[31:16];
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_post  <= post;
        cmd_imm   <= imm;
        pc        <= pc_val;
        @(posedge clk);
        cmd_valid <= 1'b0;                  // accepted on this edge
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            if (!busy) report_failure("busy went low before done");
            if (cycles == DONE_TIMEOUT) report_failure("timed out waiting for done");
            @(posedge clk);
            r = next_rand();
            cmd_valid <= junk & r[20];      // stray command while busy, must be dropped
            cmd_op    <= kcpu_pkg::cmd_op_t'(r[18:16] % 3'd6);
            cmd_post  <= r[31:24];
            cycles++;
            @(negedge clk);
        end
        case (op)
            kcpu_pkg::CMD_LD:   model_write(post[3:0], imm);
            kcpu_pkg::CMD_TFR:  model_write(post[3:0], model_read(post[7:4], pc_val));
            kcpu_pkg::CMD_PSHS: model_stack(1'b0, 1'b1, post);
            kcpu_pkg::CMD_PSHU: model_stack(1'b1, 1'b1, post);
            kcpu_pkg::CMD_PULS: model_stack(1'b0, 1'b0, post);
            kcpu_pkg::CMD_PULU: model_stack(1'b1, 1'b0, post);
            default: ;
        endcase
        compare_all();                      // results visible in the done cycle
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        if (busy || done) report_failure("busy or done still high after the done cycle");
    endtask

    initial begin
        logic [31:0]     r;
        logic [2:0]      kind;
        logic            junk;
        logic            use_u;
        kcpu_pkg::post_t mask;
        seed = 32'd60393;
        clk = 1'b0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = kcpu_pkg::CMD_LD;
        cmd_post = '0;
        cmd_imm = '0;
        pc = '0;
        {m_a, m_b, m_dp, m_cc} = '0;
        {m_x, m_y, m_u, m_s} = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_all();
        // 26 pushes of 10 bytes cover all 256 RAM bytes
        for (int k = 0; k < 26; k++) begin
            r = next_rand();
            run_cmd(kcpu_pkg::CMD_LD, 8'h00, r[31:16], 1'b0);
            r = next_rand();
            run_cmd(kcpu_pkg::CMD_LD, 8'h01, r[31:16], 1'b0);
            r = next_rand();
            run_cmd(kcpu_pkg::CMD_LD, 8'h03, r[31:16], 1'b0);
            run_cmd(kcpu_pkg::CMD_PSHS, 8'hff, 16'h0000, 1'b0);
        end
        for (int c = 0; c < 16; c++) begin
            r = next_rand();
            run_cmd(kcpu_pkg::CMD_LD, 8'(c), r[31:16], 1'b0);
        end
        for (int p = 0; p < 256; p++)
            run_cmd(kcpu_pkg::CMD_TFR, 8'(p), 16'h0000, 1'b0);   // every src/dst pair
        for (int n = 0; n < 300; n++) begin
            r = next_rand();
            kind = r[31:29];
            junk = r[28];
            use_u = r[27];
            mask = r[23:16];
            case (kind)
                3'd0, 3'd1: begin
                    r = next_rand();
                    run_cmd(kcpu_pkg::CMD_LD, mask, r[31:16], junk);
                end
                3'd2, 3'd3: run_cmd(kcpu_pkg::CMD_TFR, mask, 16'h0000, junk);
                3'd4, 3'd5: begin
                    run_cmd(use_u ? kcpu_pkg::CMD_PSHU : kcpu_pkg::CMD_PSHS, mask, '0, junk);
                    run_cmd(use_u ? kcpu_pkg::CMD_PULU : kcpu_pkg::CMD_PULS, mask, '0, junk);
                end
                3'd6: run_cmd(kcpu_pkg::cmd_op_t'(3'd2 + {1'b0, r[25:24]}), mask, '0, junk);
                default: run_cmd(kcpu_pkg::cmd_op_t'(3'd2 + {1'b0, r[25:24]}),
                                 mask & 8'h80, '0, junk);   // empty list, PC bit only
            endcase
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
